// File: flist.f
cache_pkg.sv
cache_ram_if.sv
sram_256.sv
tag_store.sv
data_store.sv
way_select.sv
cache_ctrl.sv
l1_cache_top.sv
tb_l1_cache.sv

// File: Bender.yml
package:
  name: l1_cache

sources:
  - cache_pkg.sv
  - cache_ram_if.sv
  - sram_256.sv
  - tag_store.sv
  - data_store.sv
  - way_select.sv
  - cache_ctrl.sv
  - l1_cache_top.sv
  - target: test
    files:
      - tb_l1_cache.sv

// File: tb_l1_cache.sv
//**************************************************************************
// applies a table of requests to the L1 cache array over the four-phase
// req/ack handshake and checks hit, read line and eviction
//**************************************************************************
`timescale 1ns/10ps

module tb_l1_cache;
    import cache_pkg::*;

    localparam int tag_w        = 21;
    localparam int index_w      = 8;
    localparam int line_w       = 128;
    localparam int addr_w       = tag_w + index_w;
    localparam int reset_cycles = 16;
    localparam int entry_cycles = 16;   // worst case for one handshake plus gap
    localparam int seed         = 39834;

    logic                clk = 1'b0;
    logic                reset;
    logic                req;
    cache_op_t           op;
    logic [addr_w-1:0]   addr;
    logic [line_w-1:0]   wdata;
    logic                ack;
    logic                hit;
    logic [line_w-1:0]   rdata;
    logic                evict_valid;
    logic [tag_w-1:0]    evict_tag;
    logic                evict_dirty;

    // stimulus and expected values per request
    cache_op_t           t_op [$];
    logic [addr_w-1:0]   t_addr [$];
    logic [line_w-1:0]   t_wdata [$];
    logic                t_hit [$];
    logic [line_w-1:0]   t_rdata [$];
    logic                t_ev [$];
    logic [tag_w-1:0]    t_etag [$];
    logic                t_edirty [$];

    int   num_entries = 0;
    int   pass_count  = 0;
    int   fail_count  = 0;
    logic table_ready = 1'b0;

    always #2 clk = ~clk;   // 4 ns period

    l1_cache_top #(
        .tag_w   (tag_w),
        .index_w (index_w),
        .line_w  (line_w)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .hit         (hit),
        .rdata       (rdata),
        .evict_valid (evict_valid),
        .evict_tag   (evict_tag),
        .evict_dirty (evict_dirty)
    );

    // distinct line contents per number
    function automatic logic [line_w-1:0] line_of(input int k);
        return {k[31:0], ~k[31:0], 32'h600d_0000 + k, 32'hfeed_0000 ^ k};
    endfunction

    task automatic add_entry(input cache_op_t o, input logic [tag_w-1:0] tag,
                             input logic [index_w-1:0] idx, input logic [line_w-1:0] wd,
                             input logic h, input logic [line_w-1:0] rd,
                             input logic ev, input logic [tag_w-1:0] et, input logic ed);
        t_op.push_back(o);
        t_addr.push_back({tag, idx});
        t_wdata.push_back(wd);
        t_hit.push_back(h);
        t_rdata.push_back(rd);
        t_ev.push_back(ev);
        t_etag.push_back(et);
        t_edirty.push_back(ed);
        num_entries++;
    endtask

    task automatic build_table();
        // every lookup misses in the empty cache
        add_entry(op_read,  21'h00011, 8'h10, '0, 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h1abcd, 8'hff, '0, 0, '0, 0, '0, 0);
        // fill and read back, then miss with another tag at the same set
        add_entry(op_fill,  21'h00011, 8'h10, line_of(1), 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h00011, 8'h10, '0, 1, line_of(1), 0, '0, 0);
        add_entry(op_read,  21'h00022, 8'h10, '0, 0, '0, 0, '0, 0);
        // two fills take way 0 then way 1 without eviction
        add_entry(op_fill,  21'h00100, 8'h20, line_of(2), 0, '0, 0, '0, 0);
        add_entry(op_fill,  21'h00200, 8'h20, line_of(3), 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h00100, 8'h20, '0, 1, line_of(2), 0, '0, 0);
        add_entry(op_read,  21'h00200, 8'h20, '0, 1, line_of(3), 0, '0, 0);
        // a write hit shows in the next read and a write miss changes nothing
        add_entry(op_write, 21'h00100, 8'h20, line_of(4), 1, '0, 0, '0, 0);
        add_entry(op_read,  21'h00100, 8'h20, '0, 1, line_of(4), 0, '0, 0);
        add_entry(op_write, 21'h00300, 8'h20, line_of(5), 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h00300, 8'h20, '0, 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h00200, 8'h20, '0, 1, line_of(3), 0, '0, 0);
        // way 0 is now LRU and dirty from the write
        add_entry(op_fill,  21'h00300, 8'h20, line_of(6), 0, '0, 1, 21'h00100, 1);
        add_entry(op_read,  21'h00100, 8'h20, '0, 0, '0, 0, '0, 0);
        add_entry(op_read,  21'h00300, 8'h20, '0, 1, line_of(6), 0, '0, 0);
        // way 1 not written since its fill and still clean
        add_entry(op_fill,  21'h00400, 8'h20, line_of(7), 0, '0, 1, 21'h00200, 0);
        add_entry(op_read,  21'h00400, 8'h20, '0, 1, line_of(7), 0, '0, 0);
        // fill over a present tag stays in place
        add_entry(op_fill,  21'h00400, 8'h20, line_of(8), 1, '0, 0, '0, 0);
        add_entry(op_read,  21'h00400, 8'h20, '0, 1, line_of(8), 0, '0, 0);
        add_entry(op_read,  21'h00300, 8'h20, '0, 1, line_of(6), 0, '0, 0);
        add_entry(op_write, 21'h00400, 8'h20, line_of(9), 1, '0, 0, '0, 0);
        add_entry(op_read,  21'h00300, 8'h20, '0, 1, line_of(6), 0, '0, 0);
        add_entry(op_fill,  21'h00500, 8'h20, line_of(10), 0, '0, 1, 21'h00400, 1);
        // unused op code behaves as a read
        add_entry(cache_op_t'(2'b11), 21'h00011, 8'h10, '0, 1, line_of(1), 0, '0, 0);
    endtask

    task automatic check_results(input int n, inout int errs);
        if (hit !== t_hit[n]) begin
            $display("ERROR %0t: test %0d hit is %0b, expected %0b", $time, n, hit, t_hit[n]);
            errs++;
        end
        if (rdata !== t_rdata[n]) begin
            $display("ERROR %0t: test %0d rdata is %h, expected %h",
                     $time, n, rdata, t_rdata[n]);
            errs++;
        end
        if (evict_valid !== t_ev[n]) begin
            $display("ERROR %0t: test %0d evict_valid is %0b, expected %0b",
                     $time, n, evict_valid, t_ev[n]);
            errs++;
        end
        if (evict_tag !== t_etag[n]) begin
            $display("ERROR %0t: test %0d evict_tag is %h, expected %h",
                     $time, n, evict_tag, t_etag[n]);
            errs++;
        end
        if (evict_dirty !== t_edirty[n]) begin
            $display("ERROR %0t: test %0d evict_dirty is %0b, expected %0b",
                     $time, n, evict_dirty, t_edirty[n]);
            errs++;
        end
    endtask

    task automatic run_entry(input int n);
        int errs;
        int latency;
        int hold;
        int gap;
        errs    = 0;
        latency = 0;
        hold    = $urandom_range(3, 0);   // extra cycles req stays up after ack
        gap     = $urandom_range(3, 1);   // idle cycles before the next req
        op      = t_op[n];
        addr    = t_addr[n];
        wdata   = t_wdata[n];
        req     = 1'b1;
        while (!ack && latency < 8) begin
            @(negedge clk);
            latency++;
        end
        if (!ack) begin
            $display("test %0d: ack never came after req was raised", n);
            errs++;
        end else begin
            if (latency != 2) begin
                $display("ERROR %0t: test %0d ack after %0d cycles, expected 2",
                         $time, n, latency);
                errs++;
            end
            check_results(n, errs);
            repeat (hold) begin
                @(negedge clk);
                if (!ack) begin
                    $display("ERROR %0t: test %0d ack dropped while req high", $time, n);
                    errs++;
                end
                check_results(n, errs);   // results hold with ack
            end
        end
        req = 1'b0;
        @(negedge clk);
        if (ack) begin
            $display("ERROR %0t: test %0d ack still high after req dropped", $time, n);
            errs++;
        end
        repeat (gap) @(negedge clk);
        if (errs == 0) begin
            pass_count++;
            $display("test %0d op %0d addr %h: pass", n, t_op[n], t_addr[n]);
        end else begin
            fail_count++;
            $display("test %0d op %0d addr %h: fail, %0d errors", n, t_op[n], t_addr[n], errs);
        end
    endtask

    initial begin
        int idle_errs;
        idle_errs = 0;
        void'($urandom(seed));
        reset = 1'b1;
        req   = 1'b0;
        op    = op_read;
        addr  = '0;
        wdata = '0;
        build_table();
        table_ready = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        // ack stays low with no request yet
        repeat (3) begin
            @(negedge clk);
            if (ack !== 1'b0) begin
                $display("ERROR %0t: ack is %b with no request pending", $time, ack);
                idle_errs++;
            end
        end
        if (idle_errs == 0) begin
            pass_count++;
            $display("idle after reset: pass");
        end else begin
            fail_count++;
            $display("idle after reset: fail");
        end
        for (int n = 0; n < num_entries; n++) begin
            run_entry(n);
        end
        $display("%0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog bound scales with the table length
    initial begin
        int limit;
        wait (table_ready);
        limit = reset_cycles + 8 + num_entries * entry_cycles;
        repeat (limit) @(posedge clk);
        $display("handshake hung, run stopped after %0d cycles with controller in %s",
                 limit, uut.u_ctrl.state.name());
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: l1_cache_top.sv
//**************************************************************************
// L1 cache array top level, two ways by 256 sets; a requester drives
// req, op, addr and wdata and waits for ack as a four-phase handshake
//**************************************************************************
`timescale 1ns/10ps

module l1_cache_top #(
    parameter int tag_w   = 21,
    parameter int index_w = 8,    // fixed by the 256-entry memories
    parameter int line_w  = 128
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  cache_pkg::cache_op_t     op,
    input  logic [tag_w+index_w-1:0] addr,
    input  logic [line_w-1:0]        wdata,
    output logic                     ack,
    output logic                     hit,
    output logic [line_w-1:0]        rdata,
    output logic                     evict_valid,
    output logic [tag_w-1:0]         evict_tag,
    output logic                     evict_dirty
);

    cache_ram_if #(
        .tag_w   (tag_w),
        .index_w (index_w),
        .line_w  (line_w)
    ) ram_bus ();

    cache_ctrl #(
        .tag_w   (tag_w),
        .index_w (index_w),
        .line_w  (line_w)
    ) u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .ack         (ack),
        .hit         (hit),
        .rdata       (rdata),
        .evict_valid (evict_valid),
        .evict_tag   (evict_tag),
        .evict_dirty (evict_dirty),
        .ram         (ram_bus.ctrl)
    );

    tag_store #(
        .tag_w   (tag_w),
        .index_w (index_w)
    ) u_tag_store (
        .clk   (clk),
        .reset (reset),
        .ram   (ram_bus.tag_side)
    );

    data_store #(
        .line_w (line_w)
    ) u_data_store (
        .clk (clk),
        .ram (ram_bus.data_side)
    );

    way_select #(
        .tag_w (tag_w)
    ) u_way_select (
        .ram (ram_bus.select)
    );

endmodule

// File: cache_ctrl.sv
//**************************************************************************
// four-phase req/ack sequencer; latches one request, issues the array
// writes in the lookup cycle and holds the results while ack is high
//**************************************************************************
`timescale 1ns/10ps

module cache_ctrl #(
    parameter int tag_w   = 21,
    parameter int index_w = 8,
    parameter int line_w  = 128
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  cache_pkg::cache_op_t     op,
    input  logic [tag_w+index_w-1:0] addr,
    input  logic [line_w-1:0]        wdata,
    output logic                     ack,
    output logic                     hit,
    output logic [line_w-1:0]        rdata,
    output logic                     evict_valid,
    output logic [tag_w-1:0]         evict_tag,
    output logic                     evict_dirty,
    cache_ram_if.ctrl                ram
);
    import cache_pkg::*;

    ctrl_state_t              state;
    cache_op_t                op_q;
    logic [tag_w+index_w-1:0] addr_q;
    logic [line_w-1:0]        wdata_q;
    logic                     lookup;
    logic                     do_write;
    logic                     do_fill;
    logic                     target_way;
    logic [num_ways-1:0]      target_oh;

    assign lookup = (state == st_lookup);
    assign ack    = (state == st_done);

    assign ram.index      = addr_q[index_w-1:0];
    assign ram.lookup_tag = addr_q[tag_w+index_w-1:index_w];
    assign ram.tag_wd     = addr_q[tag_w+index_w-1:index_w];
    assign ram.line_wd    = wdata_q;

    always_comb begin
        do_write   = lookup && (op_q == op_write) && ram.hit;  // write miss is a no-op
        do_fill    = lookup && (op_q == op_fill);
        // fill over a present tag stays in place
        target_way = (do_fill && !ram.hit) ? ram.victim_way : ram.hit_way;
        target_oh  = num_ways'(1) << target_way;

        ram.tag_we      = do_fill ? target_oh : '0;
        ram.data_we     = (do_fill || do_write) ? target_oh : '0;
        ram.set_dirty   = do_write;
        ram.clear_dirty = do_fill;
        ram.lru_we      = do_fill || (lookup && ram.hit);
        ram.lru_wd      = ~target_way;     // other way becomes LRU
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:   if (req) state <= st_lookup;
                st_lookup: state <= st_done;
                st_done:   if (!req) state <= st_release;
                default:   state <= st_idle;
            endcase
        end
    end

    // request latch, taken on acceptance
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hit         <= 1'b0;
            rdata       <= '0;
            evict_valid <= 1'b0;
            evict_tag   <= '0;
            evict_dirty <= 1'b0;
        end else if (lookup) begin
            hit         <= ram.hit;
            rdata       <= '0;
            evict_valid <= 1'b0;
            evict_tag   <= '0;
            evict_dirty <= 1'b0;
            case (op_q)
                op_write: ;     // only hit is reported
                op_fill: begin
                    if (!ram.hit && ram.victim_valid) begin
                        evict_valid <= 1'b1;
                        evict_tag   <= ram.victim_tag;
                        evict_dirty <= ram.victim_dirty;
                    end
                end
                default: rdata <= ram.sel_line;  // read and unused code
            endcase
        end
    end

endmodule

// File: way_select.sv
//**************************************************************************
// combines tag and data read-backs: hit detection, hit way, victim
// choice for fills and the read line of the hit way
//**************************************************************************
`timescale 1ns/10ps

module way_select #(
    parameter int tag_w = 21
) (
    cache_ram_if.select ram
);
    import cache_pkg::*;

    logic [num_ways-1:0] match;
    logic                hit;
    logic                hit_way;
    logic                victim;
    logic [tag_w-1:0]    victim_tag;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = ram.valid[w] && (ram.tag_rd[w] == ram.lookup_tag);
        end
        hit     = |match;
        hit_way = match[1];     // way 1 on its match, else way 0

        // invalid way first, way 0 before way 1, then LRU
        if (!ram.valid[0]) begin
            victim = 1'b0;
        end else if (!ram.valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = ram.lru;
        end
        victim_tag = ram.tag_rd[victim];
    end

    assign ram.hit          = hit;
    assign ram.hit_way      = hit_way;
    assign ram.victim_way   = victim;
    assign ram.victim_valid = ram.valid[victim];
    assign ram.victim_tag   = victim_tag;
    assign ram.victim_dirty = ram.dirty[victim];
    assign ram.sel_line     = hit ? ram.line_rd[hit_way] : '0;  // zero on a miss

endmodule

// File: data_store.sv
//**************************************************************************
// data side of the two-way array, one line memory per way; the enabled
// way takes line_wd, which carries the fill line or the store word
//**************************************************************************
`timescale 1ns/10ps

module data_store #(
    parameter int line_w = 128
) (
    input  logic           clk,
    cache_ram_if.data_side ram
);
    import cache_pkg::*;

    // no byte enables, so a store word covers the whole line and both
    // fill and store write line_wd; only the way strobe differs
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        sram_256 #(
            .width (line_w)
        ) u_data_way (
            .clk (clk),
            .a   (ram.index),
            .we  (ram.data_we[w]),
            .wd  (ram.line_wd),
            .rd  (ram.line_rd[w])   // follows index
        );
    end

endmodule

// File: tag_store.sv
//**************************************************************************
// tag side of the two-way array: a tag memory per way, valid and dirty
// flops per set and way, and the per-set LRU bit
//**************************************************************************
`timescale 1ns/10ps

module tag_store #(
    parameter int tag_w   = 21,
    parameter int index_w = 8
) (
    input  logic          clk,
    input  logic          reset,
    cache_ram_if.tag_side ram
);
    import cache_pkg::*;

    logic [(1 << index_w)-1:0] valid_q [num_ways];
    logic [(1 << index_w)-1:0] dirty_q [num_ways];

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        sram_256 #(
            .width (tag_w)
        ) u_tag_way (
            .clk (clk),
            .a   (ram.index),
            .we  (ram.tag_we[w]),
            .wd  (ram.tag_wd),
            .rd  (ram.tag_rd[w])
        );
    end

    // one bit per set, names the way to replace
    sram_256 #(
        .width (1)
    ) u_lru (
        .clk (clk),
        .a   (ram.index),
        .we  (ram.lru_we),
        .wd  (ram.lru_wd),
        .rd  (ram.lru)
    );

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            ram.valid[w] = valid_q[w][ram.index];
            ram.dirty[w] = dirty_q[w][ram.index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (ram.tag_we[w]) begin
                    valid_q[w][ram.index] <= 1'b1;  // new tag is live
                end
                // a fill starts clean, a store hit marks the line
                if (ram.tag_we[w] && ram.clear_dirty) begin
                    dirty_q[w][ram.index] <= 1'b0;
                end else if (ram.data_we[w] && ram.set_dirty) begin
                    dirty_q[w][ram.index] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: sram_256.sv
//**************************************************************************
// 256-word memory of configurable width, combinational read and a write
// at the rising clock edge
//**************************************************************************
`timescale 1ns/10ps

module sram_256 #(
    parameter int width = 128
) (
    input  logic             clk,
    input  logic [7:0]       a,
    input  logic             we,
    input  logic [width-1:0] wd,
    output logic [width-1:0] rd
);

    logic [width-1:0] mem [256];

    assign rd = mem[a];   // async read

    always_ff @(posedge clk) begin
        if (we) begin
            mem[a] <= wd;
        end
    end

endmodule

// File: cache_ram_if.sv
//**************************************************************************
// array access bundle shared by the controller, both stores and the
// way selector; each block connects through its own modport
//**************************************************************************
`timescale 1ns/10ps

interface cache_ram_if #(
    parameter int tag_w   = 21,
    parameter int index_w = 8,
    parameter int line_w  = 128
);
    import cache_pkg::*;

    // commands, driven by the controller
    logic [index_w-1:0]  index;
    logic [tag_w-1:0]    lookup_tag;
    logic [tag_w-1:0]    tag_wd;
    logic [num_ways-1:0] tag_we;        // one-hot way enable
    logic [num_ways-1:0] data_we;       // one-hot way enable
    logic [line_w-1:0]   line_wd;
    logic                set_dirty;     // store into the data_we way
    logic                clear_dirty;   // fill into the tag_we way
    logic                lru_we;
    logic                lru_wd;

    // tag side read-backs
    logic [tag_w-1:0]    tag_rd [num_ways];
    logic [num_ways-1:0] valid;
    logic [num_ways-1:0] dirty;
    logic                lru;           // way to replace next

    // data side read-back
    logic [line_w-1:0]   line_rd [num_ways];

    // way selector results
    logic                hit;
    logic                hit_way;
    logic                victim_way;
    logic                victim_valid;  // victim holds a live line
    logic [tag_w-1:0]    victim_tag;
    logic                victim_dirty;
    logic [line_w-1:0]   sel_line;

    modport ctrl (
        output index, lookup_tag, tag_wd, tag_we, data_we, line_wd,
               set_dirty, clear_dirty, lru_we, lru_wd,
        input  hit, hit_way, victim_way, victim_valid, victim_tag,
               victim_dirty, sel_line
    );

    modport tag_side (
        input  index, tag_wd, tag_we, data_we, set_dirty, clear_dirty,
               lru_we, lru_wd,
        output tag_rd, valid, dirty, lru
    );

    modport data_side (
        input  index, data_we, line_wd,
        output line_rd
    );

    modport select (
        input  lookup_tag, tag_rd, valid, dirty, lru, line_rd,
        output hit, hit_way, victim_way, victim_valid, victim_tag,
               victim_dirty, sel_line
    );

endinterface

// File: cache_pkg.sv
//**************************************************************************
// shared definitions of the L1 cache array: associativity, operation
// codes on the request port and the controller FSM states
//**************************************************************************
package cache_pkg;

    // associativity, sizes the per-way enable and read-back vectors
    localparam int num_ways = 2;

    // request operation, encoding 2'b11 is unused and served as a read
    typedef enum logic [1:0] {
        op_read  = 2'b00,   // lookup only
        op_write = 2'b01,   // update line on hit, mark dirty
        op_fill  = 2'b10    // install line, report eviction
    } cache_op_t;

    // handshake sequencer states
    typedef enum logic [1:0] {
        st_idle    = 2'b00, // waiting for req
        st_lookup  = 2'b01, // array read, writes at the closing edge
        st_done    = 2'b10, // ack high, results stable
        st_release = 2'b11  // req seen low, ack dropped
    } ctrl_state_t;

endpackage
